/* source/spi_cmd_config.svh */
`ifndef SPI_CMD_CONFIG_SVH
`define SPI_CMD_CONFIG_SVH

// Command word: write flag, address, data
`define SPI_CMD_W 12

// Read data width
`define SPI_RD_W 8

// clk cycles per sclk half period
`define SPI_HALF_DIV 4

// cs high gap between read-address and read-data frames, in clk cycles
`define SPI_RD_GAP 100

// Flag plus address, sent in the first read frame
`define SPI_ADDR_BITS 4

`endif

/* source/spi_cmd_pkg.sv */
`include "spi_cmd_config.svh"

package spi_cmd_pkg;

  // Bit counter wide enough for a full command frame
  typedef logic [$clog2(`SPI_CMD_W + 1) - 1:0] spi_bitcnt_t;

  // Decoded command
  typedef struct packed {
    logic                                  wr;    // 1 = write
    logic [`SPI_CMD_W - `SPI_RD_W - 2:0]   addr;
    logic [`SPI_RD_W - 1:0]                data;
  } spi_cmd_t;

  // One chip-select frame for the bit engine
  typedef struct packed {
    logic [`SPI_CMD_W - 1:0] word;  // Left aligned, MSB goes first
    spi_bitcnt_t             nbits;
  } spi_frame_t;

  typedef enum logic [2:0] {
    SEQ_IDLE    = 3'd0,
    SEQ_WRITE   = 3'd1,
    SEQ_RD_ADDR = 3'd2,
    SEQ_GAP     = 3'd3,
    SEQ_RD_DATA = 3'd4,
    SEQ_FINISH  = 3'd5
  } seq_state_e;

endpackage

/* source/cmd_intake.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module cmd_intake
  import spi_cmd_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`SPI_CMD_W - 1:0] cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    seq_busy,
  output spi_cmd_t                cmd,
  output logic                    cmd_go
);

  logic     pending_q;
  logic     cmd_go_q;
  spi_cmd_t cmd_q;
  logic     accept;

  // Pending covers the cycles before the sequencer raises busy
  assign cmd_rdy = !(pending_q || seq_busy);
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q <= 1'b0;
      cmd_go_q  <= 1'b0;
    end
    else
    begin
      cmd_go_q <= accept;
      if (accept)
        pending_q <= 1'b1;
      else if (seq_busy)
        pending_q <= 1'b0;  // Busy holds rdy low from here
    end
  end

  // Word held until the next acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q.wr   <= cmd_in[`SPI_CMD_W - 1];
      cmd_q.addr <= cmd_in[`SPI_CMD_W - 2:`SPI_RD_W];
      cmd_q.data <= cmd_in[`SPI_RD_W - 1:0];
    end
  end

  assign cmd    = cmd_q;
  assign cmd_go = cmd_go_q;

  a_go_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_go |-> !seq_busy);

endmodule

/* source/spi_sequencer.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module spi_sequencer
  import spi_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_t               cmd,
  input  logic                   cmd_go,
  output logic                   seq_busy,
  output logic                   frame_start,
  output spi_frame_t             frame,
  input  logic                   frame_done,
  input  logic [`SPI_RD_W - 1:0] rx_byte,
  output logic                   read_vld,
  output logic [`SPI_RD_W - 1:0] read_data
);

  localparam int GAP_W = $clog2(`SPI_RD_GAP + 1);

  seq_state_e             state_q;
  logic [GAP_W - 1:0]     gap_cnt;
  logic                   busy_q;
  logic                   start_q;
  logic                   read_vld_q;
  spi_frame_t             frame_q;
  logic [`SPI_RD_W - 1:0] read_data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= SEQ_IDLE;
      gap_cnt    <= '0;
      busy_q     <= 1'b0;
      start_q    <= 1'b0;
      read_vld_q <= 1'b0;
    end
    else
    begin
      start_q    <= 1'b0;
      read_vld_q <= 1'b0;
      case (state_q)
        SEQ_IDLE:
        begin
          if (cmd_go)
          begin
            busy_q  <= 1'b1;
            start_q <= 1'b1;
            state_q <= cmd.wr ? SEQ_WRITE : SEQ_RD_ADDR;
          end
        end
        SEQ_WRITE:
        begin
          if (frame_done)
          begin
            busy_q  <= 1'b0;
            state_q <= SEQ_FINISH;
          end
        end
        SEQ_RD_ADDR:
        begin
          if (frame_done)
          begin
            gap_cnt <= '0;
            state_q <= SEQ_GAP;
          end
        end
        SEQ_GAP:
        begin
          if (gap_cnt == GAP_W'(`SPI_RD_GAP - 1))
          begin
            start_q <= 1'b1;
            state_q <= SEQ_RD_DATA;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        SEQ_RD_DATA:
        begin
          if (frame_done)
          begin
            busy_q     <= 1'b0;
            read_vld_q <= 1'b1;
            state_q    <= SEQ_FINISH;
          end
        end
        default:
          state_q <= SEQ_IDLE;  // Finish and unused codes
      endcase
    end
  end

  // Frame contents, loaded with the start pulse
  always_ff @(posedge clk)
  begin
    if (state_q == SEQ_IDLE && cmd_go)
    begin
      if (cmd.wr)
      begin
        frame_q.word  <= cmd;
        frame_q.nbits <= spi_bitcnt_t'(`SPI_CMD_W);
      end
      else
      begin
        frame_q.word  <= {cmd.wr, cmd.addr, {`SPI_RD_W{1'b0}}};
        frame_q.nbits <= spi_bitcnt_t'(`SPI_ADDR_BITS);
      end
    end
    else if (state_q == SEQ_GAP)
    begin
      frame_q.word  <= '0;  // mosi stays low while reading
      frame_q.nbits <= spi_bitcnt_t'(`SPI_RD_W);
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == SEQ_RD_DATA && frame_done)
      read_data_q <= rx_byte;
  end

  assign seq_busy    = busy_q;
  assign frame_start = start_q;
  assign frame       = frame_q;
  assign read_vld    = read_vld_q;
  assign read_data   = read_data_q;

  a_start_on_entry: assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |-> state_q inside {SEQ_WRITE, SEQ_RD_ADDR, SEQ_RD_DATA}
                    && state_q != $past(state_q));

  a_vld_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> $past(state_q) == SEQ_RD_DATA && !cmd.wr);

endmodule

/* source/spi_bit_engine.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module spi_bit_engine
  import spi_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   frame_start,
  input  spi_frame_t             frame,
  output logic                   frame_done,
  output logic [`SPI_RD_W - 1:0] rx_byte,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso
);

  localparam int DIV_W = $clog2(`SPI_HALF_DIV + 1);

  logic                    cs_q;
  logic                    sclk_q;
  logic                    done_q;
  logic [DIV_W - 1:0]      div_cnt;
  spi_bitcnt_t             bit_cnt;   // Bits still to send
  logic [`SPI_CMD_W - 1:0] tx_q;
  logic [`SPI_RD_W - 1:0]  rx_q;

  logic half_end;
  logic rise_en;
  logic fall_en;
  logic end_en;

  // Every phase lasts one half period, the lead and tail included
  assign half_end = !cs_q && div_cnt == DIV_W'(`SPI_HALF_DIV - 1);
  assign rise_en  = half_end && !sclk_q && bit_cnt != '0;
  assign fall_en  = half_end && sclk_q;
  assign end_en   = half_end && !sclk_q && bit_cnt == '0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs_q    <= 1'b1;
      sclk_q  <= 1'b0;
      done_q  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      tx_q    <= '0;  // Keeps mosi low out of reset
    end
    else
    begin
      done_q <= 1'b0;
      if (frame_start)
      begin
        cs_q    <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= frame.nbits;
        tx_q    <= frame.word;
      end
      else if (!cs_q)
      begin
        if (half_end)
          div_cnt <= '0;
        else
          div_cnt <= div_cnt + 1'b1;

        if (rise_en)
          sclk_q <= 1'b1;

        if (fall_en)
        begin
          sclk_q  <= 1'b0;
          tx_q    <= {tx_q[`SPI_CMD_W - 2:0], 1'b0};  // Next bit on falling edge
          bit_cnt <= bit_cnt - 1'b1;
        end

        if (end_en)
        begin
          cs_q   <= 1'b1;
          done_q <= 1'b1;
        end
      end
    end
  end

  // miso taken as sclk goes high
  always_ff @(posedge clk)
  begin
    if (rise_en)
      rx_q <= {rx_q[`SPI_RD_W - 2:0], miso};
  end

  assign cs         = cs_q;
  assign sclk       = sclk_q;
  assign mosi       = tx_q[`SPI_CMD_W - 1];
  assign frame_done = done_q;
  assign rx_byte    = rx_q;

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk);

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |-> cs);

endmodule

/* source/spi_cmd_top.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module spi_cmd_top
  import spi_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`SPI_CMD_W - 1:0] cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output logic [`SPI_RD_W - 1:0] read_data
);

  spi_cmd_t               cmd;
  logic                   cmd_go;
  logic                   seq_busy;
  logic                   frame_start;
  spi_frame_t             frame;
  logic                   frame_done;
  logic [`SPI_RD_W - 1:0] rx_byte;

  cmd_intake u_intake (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .seq_busy (seq_busy),
    .cmd      (cmd),
    .cmd_go   (cmd_go)
  );

  spi_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_go      (cmd_go),
    .seq_busy    (seq_busy),
    .frame_start (frame_start),
    .frame       (frame),
    .frame_done  (frame_done),
    .rx_byte     (rx_byte),
    .read_vld    (read_vld),
    .read_data   (read_data)
  );

  // Owns the SPI pins
  spi_bit_engine u_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .frame       (frame),
    .frame_done  (frame_done),
    .rx_byte     (rx_byte),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso)
  );

endmodule

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module spi_slave_model
(
  input  logic rst_n,
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  localparam int ADDR_W = `SPI_CMD_W - `SPI_RD_W - 1;

  logic [`SPI_RD_W - 1:0]  regs [2 ** ADDR_W];
  logic [`SPI_CMD_W - 1:0] rx_shift;
  logic [`SPI_RD_W - 1:0]  tx_shift;
  logic [ADDR_W - 1:0]     rd_addr;
  logic                    rd_pending;
  int                      rx_bits;

  initial
  begin
    rx_shift   = '0;
    tx_shift   = '0;
    rd_addr    = '0;
    rd_pending = 1'b0;
    rx_bits    = 0;
    miso       = 1'b0;
  end

  // New frame, first read bit goes out before the first rising edge
  always @(negedge cs)
  begin
    rx_bits  = 0;
    rx_shift = '0;
    if (rd_pending)
    begin
      tx_shift = regs[rd_addr];
      miso     = tx_shift[`SPI_RD_W - 1];
    end
  end

  always @(posedge sclk)
  begin
    if (!cs)
    begin
      rx_shift = {rx_shift[`SPI_CMD_W - 2:0], mosi};
      rx_bits++;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs && rd_pending)
    begin
      tx_shift = {tx_shift[`SPI_RD_W - 2:0], 1'b0};
      miso     = tx_shift[`SPI_RD_W - 1];
    end
  end

  // Frame decode when cs goes high
  always @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2 ** ADDR_W; i++)
        regs[i] = `SPI_RD_W'(8'hA0 + i);
      rd_pending = 1'b0;
    end
    else if (rx_bits == `SPI_CMD_W && rx_shift[`SPI_CMD_W - 1])
      regs[rx_shift[`SPI_CMD_W - 2:`SPI_RD_W]] = rx_shift[`SPI_RD_W - 1:0];
    else if (rx_bits == `SPI_ADDR_BITS && !rx_shift[ADDR_W])
    begin
      rd_addr    = rx_shift[ADDR_W - 1:0];
      rd_pending = 1'b1;
    end
    else if (rx_bits == `SPI_RD_W)
    begin
      rd_pending = 1'b0;
      miso       = 1'b0;
    end
  end

endmodule

/* bench/tb_spi_cmd.sv */
`timescale 1ns/1ps
`include "spi_cmd_config.svh"

module tb_spi_cmd;

  localparam int N_CMDS     = 23;
  localparam int CMD_CYCLES = 2 * `SPI_CMD_W * 2 * `SPI_HALF_DIV + `SPI_RD_GAP + 20;
  localparam int LIMIT      = N_CMDS * CMD_CYCLES * 2;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [`SPI_CMD_W - 1:0] cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    sclk;
  logic                    cs;
  logic                    mosi;
  logic                    miso;
  logic                    read_vld;
  logic [`SPI_RD_W - 1:0]  read_data;

  logic [15:0]            lfsr = 16'd13636;
  logic [`SPI_RD_W - 1:0] mirror [8];
  int                     exp_frames [$];
  string                  cur_test = "reset";
  int                     test_errors;
  int                     total_errors;
  int                     tests_run;
  int                     tests_failed;
  int                     cmds_issued;
  int                     txns_seen;
  int                     cycles;
  logic                   cs_prev;
  logic                   sclk_prev;
  int                     rises;
  int                     gap;
  int                     exp_bits;

  always #20 clk = ~clk;

  spi_cmd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .miso  (miso)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string what, input int expected, input int actual);
    test_errors++;
    $display("** Error [%s] %s: expected 0x%0h actual 0x%0h", cur_test, what, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    test_errors++;
    $display("[%s] failure: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    @(posedge clk);  // Lets the pin monitor settle first
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    $display("test %-16s %s", cur_test, test_errors == 0 ? "ok" : "FAILED");
  endtask

  task automatic issue_cmd(input logic [`SPI_CMD_W - 1:0] word);
    @(posedge clk);
    cmd_in  <= word;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    @(posedge clk);  // Accepted on this edge
    cmd_vld <= 1'b0;
    cmds_issued++;
    @(negedge clk);
    assert (!cmd_rdy) else report_failure("cmd_rdy still high after acceptance");
  endtask

  task automatic wait_idle();
    while (!cmd_rdy)
      @(negedge clk);
    assert (cs) else report_failure("cs low after the command ended");
  endtask

  task automatic run_write(input logic [2:0] addr, input logic [7:0] data);
    exp_frames.push_back(`SPI_CMD_W);
    mirror[addr] = data;
    issue_cmd({1'b1, addr, data});
  endtask

  task automatic run_read(input logic [2:0] addr);
    logic [7:0] expected;
    expected = mirror[addr];
    exp_frames.push_back(`SPI_ADDR_BITS);
    exp_frames.push_back(`SPI_RD_W);
    issue_cmd({1'b0, addr, 8'h00});
    while (!read_vld)
    begin
      assert (!cmd_rdy) else report_failure("cmd_rdy rose before read_vld");
      @(negedge clk);
    end
    assert (read_data == expected) else report_mismatch("read_data", expected, read_data);
    wait_idle();
  endtask

  // Pin monitor, sampled away from the active clock edge
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      cs_prev   = 1'b1;
      sclk_prev = 1'b0;
      rises     = 0;
      gap       = 0;
    end
    else
    begin
      assert (!(cs && sclk)) else report_failure("sclk high while cs is high");
      if (!cs && sclk && !sclk_prev)
        rises++;
      if (cs_prev && !cs)
      begin
        if (exp_frames.size() != 0 && exp_frames[0] == `SPI_RD_W)
          assert (gap >= `SPI_RD_GAP) else report_mismatch("read gap", `SPI_RD_GAP, gap);
        rises = 0;
      end
      if (!cs_prev && cs)
      begin
        if (rises != `SPI_ADDR_BITS)
          txns_seen++;  // Address frame is only the first half of a read
        if (exp_frames.size() == 0)
          report_failure("cs frame without a command");
        else
        begin
          exp_bits = exp_frames.pop_front();
          assert (rises == exp_bits) else report_mismatch("sclk edges", exp_bits, rises);
        end
        gap = 0;
      end
      if (cs)
        gap++;
      cs_prev   = cs;
      sclk_prev = sclk;
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles in test %s", cycles, cur_test);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    logic [7:0] addr;
    logic [7:0] data;
    logic [2:0] wr_addr [6];
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
      mirror[i] = 8'(8'hA0 + i);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_idle");
    @(negedge clk);
    assert (cmd_rdy) else report_mismatch("cmd_rdy", 1, cmd_rdy);
    assert (cs) else report_mismatch("cs", 1, cs);
    assert (!sclk) else report_mismatch("sclk", 0, sclk);
    assert (!mosi) else report_mismatch("mosi", 0, mosi);
    assert (!read_vld) else report_mismatch("read_vld", 0, read_vld);
    close_test();

    start_test("unwritten_reads");
    for (int a = 0; a < 8; a++)
      run_read(3'(a));
    close_test();

    start_test("write_then_read");
    for (int i = 0; i < 6; i++)
    begin
      draw_bits(3, addr);
      draw_bits(8, data);
      wr_addr[i] = addr[2:0];
      run_write(addr[2:0], data);
      wait_idle();
    end
    for (int i = 0; i < 6; i++)
      run_read(wr_addr[i]);
    close_test();

    start_test("held_command");
    draw_bits(3, addr);
    draw_bits(8, data);
    run_write(addr[2:0], data);
    draw_bits(3, addr);
    draw_bits(8, data);
    run_write(addr[2:0], data);  // Presented while cmd_rdy is low
    wait_idle();
    run_read(addr[2:0]);
    assert (txns_seen == cmds_issued)
      else report_mismatch("cs transactions", cmds_issued, txns_seen);
    assert (exp_frames.size() == 0) else report_failure("expected cs frames never appeared");
    close_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/spi_cmd_pkg.sv
source/cmd_intake.sv
source/spi_sequencer.sv
source/spi_bit_engine.sv
source/spi_cmd_top.sv
bench/spi_slave_model.sv
bench/tb_spi_cmd.sv

/* Bender.yml */
package:
  name: spi_cmd

sources:
  - include_dirs:
      - source
    files:
      - source/spi_cmd_pkg.sv
      - source/cmd_intake.sv
      - source/spi_sequencer.sv
      - source/spi_bit_engine.sv
      - source/spi_cmd_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/spi_slave_model.sv
      - bench/tb_spi_cmd.sv
